// File: verilog/cache_geom_pkg.sv
package cache_geom_pkg;

   // byte address seen on both the front end and the back end
   localparam int ADDR_W = 32;

   // one data word, same width on both sides of the cache
   localparam int DATA_W = 32;

   // byte bits inside a word, always zero on back-end addresses
   localparam int BYTE_OFFSET_W = 2;

   typedef logic [ADDR_W-1:0] addr_t;   // byte address
   typedef logic [DATA_W-1:0] word_t;   // data word

   // an address splits into tag, line index, word offset and byte offset
   // from the top down, with the index and offset widths set per instance

endpackage

// File: verilog/cache_bus_pkg.sv
package cache_bus_pkg;

   // front-end request, valid is a single-cycle strobe
   typedef struct packed {
      logic                  valid;   // request pulse
      cache_geom_pkg::addr_t addr;    // byte address of the word to read
   } fe_req_t;

   // front-end response, valid is a single-cycle strobe
   typedef struct packed {
      logic                  valid;   // response pulse
      cache_geom_pkg::word_t rdata;   // word read from the cache
   } fe_resp_t;

   // back-end request towards the line memory
   typedef struct packed {
      logic                  valid;   // held high until ready is seen
      cache_geom_pkg::addr_t addr;    // word-aligned byte address
   } be_req_t;

   // back-end response, rdata is valid in the same cycle as ready
   typedef struct packed {
      logic                  ready;   // transfer happens when valid is also high
      cache_geom_pkg::word_t rdata;   // returned word
   } be_resp_t;

   // a word moves on the back end in every cycle where valid and ready
   // are both high, so a stalled request keeps its address unchanged

endpackage

// File: verilog/cache_read_channel.sv
`timescale 1ns/1ps

module cache_read_channel #(
   parameter int WORD_OFFSET_W = 2,
   parameter int LINE_W        = 3,
   localparam int TAG_W = cache_geom_pkg::ADDR_W - LINE_W - WORD_OFFSET_W
                          - cache_geom_pkg::BYTE_OFFSET_W
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        replace_valid,
   input  logic [TAG_W+LINE_W-1:0]     replace_addr,    // tag and index of the line
   output logic                        replace,
   output logic                        read_valid,
   output logic [WORD_OFFSET_W-1:0]    read_addr,
   output cache_geom_pkg::word_t       read_rdata,
   output cache_bus_pkg::be_req_t      be_req,
   input  cache_bus_pkg::be_resp_t     be_resp
);

   typedef enum logic [1:0] {
      IDLE,
      HANDSHAKE,
      END_HANDSHAKE
   } state_t;

   state_t                     state;
   logic [WORD_OFFSET_W-1:0]   word_counter;   // next word index
   logic                       last_word;

   assign last_word  = &read_addr;
   assign read_rdata = be_resp.rdata;           // data goes straight into the store

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE: begin
               if (replace_valid) begin
                  state <= HANDSHAKE;
               end
            end
            HANDSHAKE: begin
               if (be_resp.ready && last_word) begin
                  state <= END_HANDSHAKE;
               end
            end
            END_HANDSHAKE: begin
               // last word was written at the previous edge
               state <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

   // read_addr is the index of the word currently on the back end
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         read_addr <= '0;
      end else begin
         read_addr <= word_counter;
      end
   end

   always_comb begin
      replace      = (state != IDLE);   // covers the end cycle too
      read_valid   = 1'b0;
      word_counter = '0;                 // idle parks the counter at word 0
      be_req.valid = 1'b0;
      be_req.addr  = {replace_addr, read_addr, {cache_geom_pkg::BYTE_OFFSET_W{1'b0}}};
      if (state == HANDSHAKE) begin
         be_req.valid = 1'b1;            // held through stalls and between words
         read_valid   = be_resp.ready;
         word_counter = read_addr + WORD_OFFSET_W'(be_resp.ready);
      end
   end

endmodule

// File: verilog/cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store #(
   parameter int WORD_OFFSET_W = 2,
   parameter int LINE_W        = 3,
   localparam int TAG_W = cache_geom_pkg::ADDR_W - LINE_W - WORD_OFFSET_W
                          - cache_geom_pkg::BYTE_OFFSET_W
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic [LINE_W-1:0]         lookup_index,
   input  logic [TAG_W-1:0]          lookup_tag,
   output logic                      hit,
   input  logic                      replace,
   input  logic [TAG_W+LINE_W-1:0]   replace_addr
);

   localparam int LINES = 2 ** LINE_W;

   logic [TAG_W-1:0]          tags [LINES];
   logic [LINES-1:0]          line_valid;
   logic                      replace_q;
   logic [TAG_W+LINE_W-1:0]   refill_addr;   // line being refilled
   logic                      commit;

   assign commit = replace_q & ~replace;      // falling edge of replace

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         line_valid <= '0;
         replace_q  <= 1'b0;
         hit        <= 1'b0;
      end else begin
         replace_q <= replace;
         hit       <= line_valid[lookup_index] && (tags[lookup_index] == lookup_tag);
         // the victim line is not usable while its words are overwritten
         if (replace && !replace_q) begin
            line_valid[replace_addr[LINE_W-1:0]] <= 1'b0;
         end else if (commit) begin
            line_valid[refill_addr[LINE_W-1:0]] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (replace) begin
         refill_addr <= replace_addr;
      end
      if (commit) begin
         tags[refill_addr[LINE_W-1:0]] <= refill_addr[TAG_W+LINE_W-1:LINE_W];
      end
   end

endmodule

// File: verilog/cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store #(
   parameter int WORD_OFFSET_W = 2,
   parameter int LINE_W        = 3
) (
   input  logic                       clk,
   input  logic [LINE_W-1:0]          rd_index,
   input  logic [WORD_OFFSET_W-1:0]   rd_offset,
   output cache_geom_pkg::word_t      rdata,
   input  logic [LINE_W-1:0]          write_line,   // line under refill
   input  logic                       read_valid,
   input  logic [WORD_OFFSET_W-1:0]   read_addr,
   input  cache_geom_pkg::word_t      read_rdata
);

   localparam int DEPTH = 2 ** (LINE_W + WORD_OFFSET_W);

   // words of one line sit at consecutive locations
   cache_geom_pkg::word_t mem [DEPTH];

   always_ff @(posedge clk) begin
      if (read_valid) begin
         mem[{write_line, read_addr}] <= read_rdata;   // one refill word per transfer
      end
      rdata <= mem[{rd_index, rd_offset}];   // registered read, valid the next cycle
   end

   // the read port and the refill port never collide on the same line in use,
   // since the front end waits for the refill before reading again

endmodule

// File: verilog/cache_control.sv
`timescale 1ns/1ps

module cache_control #(
   parameter int WORD_OFFSET_W = 2,
   parameter int LINE_W        = 3,
   localparam int TAG_W = cache_geom_pkg::ADDR_W - LINE_W - WORD_OFFSET_W
                          - cache_geom_pkg::BYTE_OFFSET_W
) (
   input  logic                       clk,
   input  logic                       reset,
   input  cache_bus_pkg::fe_req_t     fe_req,
   output cache_bus_pkg::fe_resp_t    fe_resp,
   output logic [LINE_W-1:0]          lookup_index,
   output logic [TAG_W-1:0]           lookup_tag,
   output logic [WORD_OFFSET_W-1:0]   rd_offset,
   input  logic                       hit,
   input  cache_geom_pkg::word_t      rdata,
   output logic                       replace_valid,
   output logic [TAG_W+LINE_W-1:0]    replace_addr,
   input  logic                       replace
);

   localparam int OFF_LO = cache_geom_pkg::BYTE_OFFSET_W;
   localparam int IDX_LO = OFF_LO + WORD_OFFSET_W;
   localparam int TAG_LO = IDX_LO + LINE_W;

   typedef enum logic [2:0] {
      IDLE,
      LOOKUP,    // stores answer for the registered lookup
      MISS,      // refill requested, waiting for the read channel
      REFILL,    // line is being fetched
      REREAD     // stores are read again with the new line in place
   } state_t;

   state_t                  state;
   state_t                  state_next;
   cache_geom_pkg::addr_t   addr_q;
   cache_geom_pkg::addr_t   lookup_addr;

   always_ff @(posedge clk) begin
      if (fe_req.valid) begin
         addr_q <= fe_req.addr;
      end
   end

   // the request edge itself starts the lookup so a hit answers one cycle later
   assign lookup_addr  = fe_req.valid ? fe_req.addr : addr_q;
   assign lookup_index = lookup_addr[IDX_LO +: LINE_W];
   assign lookup_tag   = lookup_addr[TAG_LO +: TAG_W];
   assign rd_offset    = lookup_addr[OFF_LO +: WORD_OFFSET_W];

   assign replace_addr  = addr_q[cache_geom_pkg::ADDR_W-1:IDX_LO];
   assign replace_valid = (state == MISS);   // dropped once replace is seen

   assign fe_resp = '{valid: (state == LOOKUP) && hit, rdata: rdata};

   always_comb begin
      state_next = state;
      case (state)
         IDLE: begin
            if (fe_req.valid) begin
               state_next = LOOKUP;
            end
         end
         LOOKUP: begin
            state_next = hit ? IDLE : MISS;
         end
         MISS: begin
            if (replace) begin
               state_next = REFILL;
            end
         end
         REFILL: begin
            // the tag store commits the new line at this edge
            if (!replace) begin
               state_next = REREAD;
            end
         end
         REREAD: begin
            state_next = LOOKUP;   // the lookup now hits and answers
         end
         default: begin
            state_next = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         state <= state_next;
      end
   end

endmodule

// File: verilog/cache_top.sv
`timescale 1ns/1ps

module cache_top #(
   parameter int WORD_OFFSET_W = 2,
   parameter int LINE_W        = 3,
   localparam int TAG_W = cache_geom_pkg::ADDR_W - LINE_W - WORD_OFFSET_W
                          - cache_geom_pkg::BYTE_OFFSET_W
) (
   input  logic                      clk,
   input  logic                      reset,
   input  cache_bus_pkg::fe_req_t    fe_req,
   output cache_bus_pkg::fe_resp_t   fe_resp,
   output cache_bus_pkg::be_req_t    be_req,
   input  cache_bus_pkg::be_resp_t   be_resp
);

   logic [LINE_W-1:0]          lookup_index;
   logic [TAG_W-1:0]           lookup_tag;
   logic [WORD_OFFSET_W-1:0]   rd_offset;
   logic                       hit;
   cache_geom_pkg::word_t      rdata;
   logic                       replace_valid;
   logic [TAG_W+LINE_W-1:0]    replace_addr;
   logic                       replace;
   logic                       read_valid;
   logic [WORD_OFFSET_W-1:0]   read_addr;
   cache_geom_pkg::word_t      read_rdata;

   cache_control #(.WORD_OFFSET_W(WORD_OFFSET_W), .LINE_W(LINE_W)) control_i (
      .clk, .reset, .fe_req, .fe_resp, .lookup_index, .lookup_tag, .rd_offset,
      .hit, .rdata, .replace_valid, .replace_addr, .replace
   );

   cache_tag_store #(.WORD_OFFSET_W(WORD_OFFSET_W), .LINE_W(LINE_W)) tag_store_i (
      .clk, .reset, .lookup_index, .lookup_tag, .hit, .replace, .replace_addr
   );

   cache_data_store #(.WORD_OFFSET_W(WORD_OFFSET_W), .LINE_W(LINE_W)) data_store_i (
      .clk,
      .rd_index   (lookup_index),
      .rd_offset,
      .rdata,
      .write_line (replace_addr[LINE_W-1:0]),   // index part of the line address
      .read_valid,
      .read_addr,
      .read_rdata
   );

   cache_read_channel #(.WORD_OFFSET_W(WORD_OFFSET_W), .LINE_W(LINE_W)) read_channel_i (
      .clk, .reset, .replace_valid, .replace_addr, .replace,
      .read_valid, .read_addr, .read_rdata, .be_req, .be_resp
   );

endmodule

// File: verif/cache_mem_model.sv
`timescale 1ns/1ps

module cache_mem_model #(
   parameter int MAX_STALL = 3,   // longest run of cycles with ready low
   parameter int LOG_W     = 8
) (
   input  logic                      clk,
   input  logic                      reset,
   input  cache_bus_pkg::be_req_t    be_req,
   output cache_bus_pkg::be_resp_t   be_resp,
   output int                        xfer_count
);

   cache_geom_pkg::addr_t   log_addr [2 ** LOG_W];   // address of every accepted transfer
   int                      count = 0;
   int                      stall_run = 0;
   logic                    ready_q = 1'b0;
   cache_geom_pkg::word_t   rdata_q = '0;

   assign be_resp    = '{ready: ready_q, rdata: rdata_q};
   assign xfer_count = count;

   // memory contents are a fixed scramble of the word address
   function automatic cache_geom_pkg::word_t stored_word(input cache_geom_pkg::addr_t addr);
      cache_geom_pkg::word_t w;
      w = cache_geom_pkg::word_t'(addr >> cache_geom_pkg::BYTE_OFFSET_W);
      return (w * 32'h9e37_79b1) ^ {w[15:0], w[31:16]} ^ 32'h5a5a_c3c3;
   endfunction

   always @(negedge clk) begin
      if (reset) begin
         ready_q   <= 1'b0;
         stall_run <= 0;
      end else if (stall_run >= MAX_STALL || ($urandom % 4) != 0) begin
         ready_q   <= 1'b1;
         stall_run <= 0;
      end else begin
         ready_q   <= 1'b0;                 // random stall
         stall_run <= stall_run + 1;
      end
      rdata_q <= stored_word(be_req.addr);   // address is stable since the rising edge
   end

   always @(posedge clk) begin
      if (!reset && be_req.valid && be_resp.ready) begin
         log_addr[LOG_W'(count)] <= be_req.addr;
         count                   <= count + 1;
      end
   end

endmodule

// File: verif/cache_assertions.sv
`timescale 1ns/1ps

module cache_assertions (
   input logic                      clk,
   input logic                      reset,
   input logic                      replace,
   input logic                      read_valid,
   input cache_bus_pkg::be_req_t    be_req,
   input cache_bus_pkg::be_resp_t   be_resp
);

   // a stalled request keeps its valid and its address
   stall_hold: assert property (@(posedge clk) disable iff (reset)
      (be_req.valid && !be_resp.ready) |=> (be_req.valid && $stable(be_req.addr)))
      else $error("back-end request changed while ready was low");

   quiet_after_reset: assert property (@(posedge clk)
      (reset || $past(reset)) |-> !be_req.valid)
      else $error("back-end valid high during or right after reset");

   // every refill write sits inside replace and is followed by at least one more replace cycle
   write_in_refill: assert property (@(posedge clk) disable iff (reset)
      read_valid |=> (replace && $past(replace)))
      else $error("refill write outside of a replace window or in its last cycle");

endmodule

bind cache_read_channel cache_assertions assertions_i (
   .clk, .reset, .replace, .read_valid, .be_req, .be_resp
);

// File: verif/cache_tb.sv
`timescale 1ns/1ps

module cache_tb;

   localparam int WORD_OFFSET_W = 2;
   localparam int LINE_W        = 3;
   localparam int TAG_W  = cache_geom_pkg::ADDR_W - LINE_W - WORD_OFFSET_W
                           - cache_geom_pkg::BYTE_OFFSET_W;
   localparam int WORDS  = 2 ** WORD_OFFSET_W;
   localparam int LINES  = 2 ** LINE_W;
   localparam int IDX_LO = cache_geom_pkg::BYTE_OFFSET_W + WORD_OFFSET_W;
   localparam int TAG_LO = IDX_LO + LINE_W;
   localparam int MAX_STALL    = 3;
   localparam int LOG_W        = 8;
   localparam int RESET_CYCLES = 3;
   localparam int NUM_REQUESTS = LINES + 16 + 6 + 60;
   // lookup, miss, every word at its longest stall, end cycle, reread, answer and gap
   localparam int REQ_CYCLES   = WORDS * (MAX_STALL + 1) + 8;
   localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_REQUESTS * REQ_CYCLES + 20;
   localparam cache_geom_pkg::addr_t LINE_MASK = cache_geom_pkg::addr_t'(WORDS * 4 - 1);

   typedef struct packed {
      cache_geom_pkg::addr_t addr;
      logic                  hit;           // predicted from the tag model
      int                    start_cycle;
      int                    start_xfers;
   } pending_t;

   logic                      clk = 1'b0;
   logic                      reset = 1'b1;
   cache_bus_pkg::fe_req_t    fe_req = '0;
   cache_bus_pkg::fe_resp_t   fe_resp;
   cache_bus_pkg::be_req_t    be_req;
   cache_bus_pkg::be_resp_t   be_resp;
   int                        xfer_count;

   pending_t            pending [$];
   logic [TAG_W-1:0]    model_tag [LINES];
   logic [LINES-1:0]    model_valid = '0;
   int cycle_count = 0;
   int responses = 0;
   int requests = 0;
   int hits = 0;
   int checks = 0;
   int errors = 0;

   cache_top #(.WORD_OFFSET_W(WORD_OFFSET_W), .LINE_W(LINE_W)) dut_i (
      .clk, .reset, .fe_req, .fe_resp, .be_req, .be_resp
   );

   cache_mem_model #(.MAX_STALL(MAX_STALL), .LOG_W(LOG_W)) mem_i (
      .clk, .reset, .be_req, .be_resp, .xfer_count
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
   end

   function automatic cache_geom_pkg::word_t expected_word(input cache_geom_pkg::addr_t addr);
      cache_geom_pkg::word_t w;
      w = cache_geom_pkg::word_t'(addr >> cache_geom_pkg::BYTE_OFFSET_W);
      return (w * 32'h9e37_79b1) ^ {w[15:0], w[31:16]} ^ 32'h5a5a_c3c3;
   endfunction

   function automatic cache_geom_pkg::addr_t make_addr(input logic [TAG_W-1:0] tag,
         input logic [LINE_W-1:0] index, input logic [WORD_OFFSET_W-1:0] offset);
      return {tag, index, offset, {cache_geom_pkg::BYTE_OFFSET_W{1'b0}}};
   endfunction

   function automatic logic [WORD_OFFSET_W-1:0] random_offset();
      return WORD_OFFSET_W'($urandom);
   endfunction

   task automatic check_word(input cache_geom_pkg::word_t actual,
         input cache_geom_pkg::word_t expected, input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic check_addr(input cache_geom_pkg::addr_t actual,
         input cache_geom_pkg::addr_t expected, input string what);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      end
   endtask

   task automatic check_count(input int actual, input int expected, input string what);
      checks++;
      if (actual != expected) begin
         errors++;
         $display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
      end
   endtask

   task automatic compare_response();
      pending_t                entry;
      int                      new_xfers;
      cache_geom_pkg::addr_t   line_base;
      if (pending.size() == 0) begin
         errors++;
         $display("unexpected response at %0t ns with no request outstanding", $time);
      end else begin
         entry     = pending.pop_front();
         new_xfers = xfer_count - entry.start_xfers;
         check_word(fe_resp.rdata, expected_word(entry.addr), "read data");
         if (entry.hit) begin
            check_count(new_xfers, 0, "back-end transfers on a hit");
            check_count(cycle_count - entry.start_cycle, 1, "hit latency");
         end else begin
            check_count(new_xfers, WORDS, "back-end transfers on a refill");
            line_base = entry.addr & ~LINE_MASK;   // refill starts at word 0 of the line
            for (int i = 0; i < WORDS; i++) begin
               check_addr(mem_i.log_addr[LOG_W'(entry.start_xfers + i)],
                          line_base + cache_geom_pkg::addr_t'(4 * i), "refill word address");
            end
         end
         responses++;
      end
   endtask

   // responses are taken while the DUT outputs are settled
   always @(negedge clk) begin
      if (fe_resp.valid) begin
         compare_response();
      end
   end

   // called on a falling edge, returns on a falling edge once the answer is in
   task automatic issue_request(input cache_geom_pkg::addr_t addr);
      pending_t              entry;
      logic [LINE_W-1:0]     index;
      logic [TAG_W-1:0]      tag;
      int                    target;
      index             = addr[IDX_LO +: LINE_W];
      tag               = addr[TAG_LO +: TAG_W];
      entry.addr        = addr;
      entry.hit         = model_valid[index] && (model_tag[index] == tag);
      entry.start_cycle = cycle_count;
      entry.start_xfers = xfer_count;
      model_valid[index] = 1'b1;
      model_tag[index]   = tag;
      pending.push_back(entry);
      target = responses + 1;
      requests++;
      if (entry.hit) begin
         hits++;
      end
      fe_req = '{valid: 1'b1, addr: addr};
      @(negedge clk);
      fe_req.valid = 1'b0;
      @(posedge clk);
      while (responses < target) begin
         @(posedge clk);
      end
      @(negedge clk);
   endtask

   task automatic report_test(input string name, input int count, input int errors_before);
      $display("test %-10s %0d requests, %0d errors", name, count, errors - errors_before);
   endtask

   task automatic run_tests();
      logic [LINE_W-1:0]   index;
      logic [TAG_W-1:0]    tag_pool [3];
      logic [TAG_W-1:0]    base_tag;
      int                  errors_before;
      errors_before = errors;
      for (int i = 0; i < LINES; i++) begin   // every line is cold after reset
         issue_request(make_addr(TAG_W'($urandom), LINE_W'(i), random_offset()));
      end
      report_test("cold", LINES, errors_before);
      errors_before = errors;
      for (int i = 0; i < 16; i++) begin
         index = LINE_W'($urandom);
         issue_request(make_addr(model_tag[index], index, random_offset()));
      end
      report_test("resident", 16, errors_before);
      errors_before = errors;
      index    = LINE_W'($urandom);
      base_tag = model_tag[index];
      for (int i = 0; i < 6; i++) begin   // both tags differ from the resident one
         issue_request(make_addr(base_tag ^ TAG_W'(2 + i % 2), index, random_offset()));
      end
      report_test("conflict", 6, errors_before);
      errors_before = errors;
      for (int i = 0; i < 3; i++) begin
         tag_pool[i] = TAG_W'($urandom);
      end
      for (int i = 0; i < 60; i++) begin
         issue_request(make_addr(tag_pool[$urandom % 3], LINE_W'($urandom), random_offset()));
      end
      report_test("random", 60, errors_before);
   endtask

   initial begin
      while (cycle_count < CYCLE_LIMIT) begin
         @(posedge clk);
      end
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Checks failed");
      $finish;
   end

   initial begin
      void'($urandom(69459));
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      run_tests();
      $display("requests %0d, hits %0d, refills %0d, checks %0d, errors %0d",
               requests, hits, requests - hits, checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: filelist.f
verilog/cache_geom_pkg.sv
verilog/cache_bus_pkg.sv
verilog/cache_read_channel.sv
verilog/cache_tag_store.sv
verilog/cache_data_store.sv
verilog/cache_control.sv
verilog/cache_top.sv
verif/cache_mem_model.sv
verif/cache_assertions.sv
verif/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the cache testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module cache_tb -f filelist.f
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/Vcache_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -qx "All checks passed"; then
   exit 0
fi
echo "pass line not found in the simulation output"
exit 1
